// ==== verilog/dot_pkg.sv ====
`default_nettype none

package dot_pkg;

    // frame outcome, first over/underflow wins
    typedef enum logic [1:0] {
        sat_none  = 2'b00,
        sat_over  = 2'b01,
        sat_under = 2'b10
    } sat_t;

    localparam int PAIR_WIDTH = 16;

    // one signed fixed-point sample
    typedef logic signed [PAIR_WIDTH-1:0] pair_word_t;

    // sample pair as it travels on the input stream, a in the upper half
    typedef struct packed {
        pair_word_t a;
        pair_word_t b;
    } pair_t;

endpackage

`default_nettype wire

// ==== verilog/sample_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one stream word per valid strobe, throttled upstream
interface sample_if #(
    parameter type payload_t = logic
);

    payload_t data;
    logic     valid;
    // frame marks, only meaningful while valid is high
    logic     sof;
    logic     eof;

    modport src (
        output data,
        output valid,
        output sof,
        output eof
    );

    modport dst (
        input data,
        input valid,
        input sof,
        input eof
    );

endinterface

`default_nettype wire

// ==== verilog/req_ack_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_ack_rx
    import dot_pkg::*;
#(
    parameter int  IN_WIDTH = 16,
    parameter int  IN_FRAC  = 12,
    parameter type word_t   = pair_t
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_req,
    output logic                      in_ack,
    input  wire signed [IN_WIDTH-1:0] in_a,
    input  wire signed [IN_WIDTH-1:0] in_b,
    input  wire                       in_sof,
    input  wire                       in_eof,
    input  wire                       ready,
    sample_if.src                     pair_out
);

    typedef enum logic {
        st_idle,
        st_ack
    } state_t;

    state_t state;
    word_t  pair_q;
    logic   sof_q;
    logic   eof_q;
    logic   valid_q;
    logic   accept;

    // the stream word must hold exactly one a and one b
    if ($bits(word_t) != 2 * IN_WIDTH) begin : g_width_check
        $error("word_t does not hold two IN_WIDTH samples");
    end
    if (IN_FRAC >= IN_WIDTH) begin : g_frac_check
        $error("IN_FRAC leaves no integer bit in the samples");
    end

    // new request, and the result queue still has room
    assign accept = (state == st_idle) && in_req && ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    // hold ack until the source lets go of req
                    if (!in_req) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pair_q <= word_t'({in_a, in_b});
            sof_q  <= in_sof;
            eof_q  <= in_eof;
        end
    end

    assign in_ack         = (state == st_ack);
    assign pair_out.data  = pair_q;
    assign pair_out.valid = valid_q;
    assign pair_out.sof   = sof_q;
    assign pair_out.eof   = eof_q;

    // ack rises only while the source still holds req
    assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> in_req);

endmodule

`default_nettype wire

// ==== verilog/fixed_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_mult #(
    parameter int IN_WIDTH  = 16,
    parameter int IN_FRAC   = 12,
    parameter int ACC_WIDTH = 32,
    parameter int ACC_FRAC  = 18
) (
    input  wire   clk,
    input  wire   rst,
    sample_if.dst pair_in,
    sample_if.src prod_out
);

    localparam int PROD_W = 2 * IN_WIDTH;
    // positive means the product moves left
    localparam int SHIFT  = ACC_FRAC - 2 * IN_FRAC;
    localparam int LEFT   = (SHIFT > 0) ? SHIFT : 0;
    // room for the full product plus any left shift
    localparam int EXT_W  = ((PROD_W > ACC_WIDTH) ? PROD_W : ACC_WIDTH) + LEFT;

    logic signed [IN_WIDTH-1:0]  a;
    logic signed [IN_WIDTH-1:0]  b;
    logic signed [PROD_W-1:0]    prod;
    logic signed [EXT_W-1:0]     prod_ext;
    logic signed [EXT_W-1:0]     aligned;
    logic signed [ACC_WIDTH-1:0] word_q;
    logic                        valid_q;
    logic                        sof_q;
    logic                        eof_q;

    assign a = pair_in.data.a;
    assign b = pair_in.data.b;

    // full precision, 2*IN_FRAC fraction bits
    assign prod     = a * b;
    assign prod_ext = EXT_W'(prod);

    generate
        if (SHIFT > 0) begin : g_shift_left
            assign aligned = prod_ext <<< SHIFT;
        end else if (SHIFT < 0) begin : g_shift_right
            // truncation, rounds toward minus infinity
            assign aligned = prod_ext >>> (-SHIFT);
        end else begin : g_no_shift
            assign aligned = prod_ext;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pair_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        word_q <= aligned[ACC_WIDTH-1:0];
        sof_q  <= pair_in.sof;
        eof_q  <= pair_in.eof;
    end

    assign prod_out.data  = word_q;
    assign prod_out.valid = valid_q;
    assign prod_out.sof   = sof_q;
    assign prod_out.eof   = eof_q;

endmodule

`default_nettype wire

// ==== verilog/sat_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module sat_acc
    import dot_pkg::*;
#(
    parameter int ACC_WIDTH = 32
) (
    input  wire                         clk,
    input  wire                         rst,
    sample_if.dst                       prod_in,
    output logic signed [ACC_WIDTH-1:0] sum,
    output sat_t                        flag,
    output logic                        done
);

    localparam logic signed [ACC_WIDTH-1:0] SUM_MAX = {1'b0, {(ACC_WIDTH-1){1'b1}}};
    localparam logic signed [ACC_WIDTH-1:0] SUM_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};

    // accumulate stage
    logic signed [ACC_WIDTH-1:0] acc;
    logic                        chk_valid;
    logic                        chk_sof;
    logic                        chk_eof;
    logic                        acc_sign_prev;
    logic                        add_sign;

    // check stage
    sat_t                        sticky;
    logic signed [ACC_WIDTH-1:0] acc_r;
    logic                        res_valid;

    // wrap-around sum, a sof word starts over
    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            chk_valid <= 1'b0;
            chk_eof   <= 1'b0;
        end else begin
            chk_valid <= prod_in.valid;
            chk_eof   <= prod_in.valid && prod_in.eof;
            if (prod_in.valid) begin
                if (prod_in.sof) begin
                    acc <= prod_in.data;
                end else begin
                    acc <= acc + prod_in.data;
                end
            end
        end
    end

    // operand signs of the addition just made, checked one stage later
    always_ff @(posedge clk) begin
        acc_sign_prev <= acc[ACC_WIDTH-1];
        add_sign      <= prod_in.data[ACC_WIDTH-1];
        chk_sof       <= prod_in.sof;
    end

    // equal operand signs but a flipped sum sign means the addition wrapped
    always_ff @(posedge clk) begin
        if (rst) begin
            sticky    <= sat_none;
            res_valid <= 1'b0;
        end else begin
            res_valid <= chk_eof;
            if (chk_valid) begin
                if (chk_sof) begin
                    sticky <= sat_none;
                end else if (sticky == sat_none) begin
                    if (!acc_sign_prev && !add_sign && acc[ACC_WIDTH-1]) begin
                        sticky <= sat_over;
                    end else if (acc_sign_prev && add_sign && !acc[ACC_WIDTH-1]) begin
                        sticky <= sat_under;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        acc_r <= acc;
    end

    // result stage
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            flag <= sticky;
            case (sticky)
                sat_over:  sum <= SUM_MAX;
                sat_under: sum <= SUM_MIN;
                default:   sum <= acc_r;
            endcase
        end
    end

    // one strobe per frame, frames never end on back-to-back cycles
    assert property (@(posedge clk) disable iff (rst)
        done |=> !done);

endmodule

`default_nettype wire

// ==== verilog/result_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_tx
    import dot_pkg::*;
#(
    parameter int ACC_WIDTH    = 32,
    parameter int RESULT_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire signed [ACC_WIDTH-1:0]  sum,
    input  wire sat_t                   flag,
    input  wire                         done,
    output logic                        ready,
    output logic                        out_req,
    input  wire                         out_ack,
    output logic signed [ACC_WIDTH-1:0] out_sum,
    output sat_t                        out_sat
);

    localparam int PTR_W = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release
    } state_t;

    logic signed [ACC_WIDTH-1:0] sum_mem [RESULT_DEPTH];
    sat_t                        flag_mem [RESULT_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    state_t                      state;
    logic                        pop;

    // margin for the two results that may still be in flight
    if (RESULT_DEPTH < 3) begin : g_depth_check
        $error("RESULT_DEPTH must be at least 3");
    end

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RESULT_DEPTH - 1)) begin
            return '0;
        end else begin
            return ptr + 1'b1;
        end
    endfunction

    always_ff @(posedge clk) begin
        if (done) begin
            sum_mem[wr_ptr]  <= sum;
            flag_mem[wr_ptr] <= flag;
        end
    end

    // entry leaves once the sink has acknowledged it
    assign pop = (state == st_req) && out_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (done) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({done, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // four-phase sender
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (count != '0) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (out_ack) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    // wait for the sink to drop ack before the next word
                    if (!out_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign out_req = (state == st_req);
    assign out_sum = sum_mem[rd_ptr];
    assign out_sat = flag_mem[rd_ptr];
    assign ready   = (count <= CNT_W'(RESULT_DEPTH - 3));

    // the ready margin upstream must keep every result
    assert property (@(posedge clk) disable iff (rst)
        done |-> (count < CNT_W'(RESULT_DEPTH)));

endmodule

`default_nettype wire

// ==== verilog/frame_dot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_dot_top
    import dot_pkg::*;
#(
    parameter int IN_WIDTH     = 16,
    parameter int IN_FRAC      = 12,
    parameter int ACC_WIDTH    = 32,
    parameter int ACC_FRAC     = 18,
    parameter int RESULT_DEPTH = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        in_req,
    output wire                        in_ack,
    input  wire signed [IN_WIDTH-1:0]  in_a,
    input  wire signed [IN_WIDTH-1:0]  in_b,
    input  wire                        in_sof,
    input  wire                        in_eof,
    output wire                        out_req,
    input  wire                        out_ack,
    output wire signed [ACC_WIDTH-1:0] out_sum,
    output wire sat_t                  out_sat
);

    wire                        ready;
    wire signed [ACC_WIDTH-1:0] acc_sum;
    wire sat_t                  acc_flag;
    wire                        acc_done;

    // raw pairs, then aligned products
    sample_if #(.payload_t(pair_t)) pair_if ();
    sample_if #(.payload_t(logic signed [ACC_WIDTH-1:0])) prod_if ();

    req_ack_rx #(
        .IN_WIDTH (IN_WIDTH),
        .IN_FRAC  (IN_FRAC),
        .word_t   (pair_t)
    ) i_rx (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_sof   (in_sof),
        .in_eof   (in_eof),
        .ready    (ready),
        .pair_out (pair_if.src)
    );

    fixed_mult #(
        .IN_WIDTH  (IN_WIDTH),
        .IN_FRAC   (IN_FRAC),
        .ACC_WIDTH (ACC_WIDTH),
        .ACC_FRAC  (ACC_FRAC)
    ) i_mult (
        .clk      (clk),
        .rst      (rst),
        .pair_in  (pair_if.dst),
        .prod_out (prod_if.src)
    );

    sat_acc #(
        .ACC_WIDTH (ACC_WIDTH)
    ) i_acc (
        .clk     (clk),
        .rst     (rst),
        .prod_in (prod_if.dst),
        .sum     (acc_sum),
        .flag    (acc_flag),
        .done    (acc_done)
    );

    result_tx #(
        .ACC_WIDTH    (ACC_WIDTH),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) i_tx (
        .clk     (clk),
        .rst     (rst),
        .sum     (acc_sum),
        .flag    (acc_flag),
        .done    (acc_done),
        .ready   (ready),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_sum (out_sum),
        .out_sat (out_sat)
    );

endmodule

`default_nettype wire

// ==== test/tb_frame_dot.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_dot
    import dot_pkg::*;
;

    localparam int IN_WIDTH     = 16;
    localparam int IN_FRAC      = 12;
    localparam int ACC_WIDTH    = 32;
    localparam int ACC_FRAC     = 18;
    localparam int RESULT_DEPTH = 4;
    localparam int TIMEOUT      = 2000;

    // product alignment, left or right by the fraction difference
    localparam int SHIFT  = ACC_FRAC - 2 * IN_FRAC;
    localparam int LSHIFT = (SHIFT > 0) ? SHIFT : 0;
    localparam int RSHIFT = (SHIFT < 0) ? -SHIFT : 0;

    localparam logic signed [ACC_WIDTH-1:0] SUM_MAX = {1'b0, {(ACC_WIDTH-1){1'b1}}};
    localparam logic signed [ACC_WIDTH-1:0] SUM_MIN = {1'b1, {(ACC_WIDTH-1){1'b0}}};

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        in_req;
    logic                        in_ack;
    logic signed [IN_WIDTH-1:0]  in_a;
    logic signed [IN_WIDTH-1:0]  in_b;
    logic                        in_sof;
    logic                        in_eof;
    logic                        out_req;
    logic                        out_ack;
    logic signed [ACC_WIDTH-1:0] out_sum;
    sat_t                        out_sat;

    // current frame and the results still owed by the DUT
    int                          fa[$];
    int                          fb[$];
    logic signed [ACC_WIDTH-1:0] exp_sum_q[$];
    sat_t                        exp_flag_q[$];

    int     value_errors = 0;
    int     protocol_errors = 0;
    int     max_ack_wait = 0;
    integer seed = 17;

    always #5 clk = ~clk;

    frame_dot_top #(
        .IN_WIDTH     (IN_WIDTH),
        .IN_FRAC      (IN_FRAC),
        .ACC_WIDTH    (ACC_WIDTH),
        .ACC_FRAC     (ACC_FRAC),
        .RESULT_DEPTH (RESULT_DEPTH)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_a    (in_a),
        .in_b    (in_b),
        .in_sof  (in_sof),
        .in_eof  (in_eof),
        .out_req (out_req),
        .out_ack (out_ack),
        .out_sum (out_sum),
        .out_sat (out_sat)
    );

    task automatic print_counts();
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        protocol_errors++;
        print_counts();
        $display("Verification failed");
        $finish;
    endtask

    // exact product, aligned to the accumulator point and cut to its width
    function automatic logic signed [ACC_WIDTH-1:0] align(input int a, input int b);
        longint p;
        p = longint'(a) * longint'(b);
        p = (p <<< LSHIFT) >>> RSHIFT;
        return p[ACC_WIDTH-1:0];
    endfunction

    task automatic push_expected();
        logic signed [ACC_WIDTH-1:0] acc;
        logic signed [ACC_WIDTH-1:0] pw;
        logic signed [ACC_WIDTH-1:0] nxt;
        sat_t                        fl;
        acc = '0;
        fl  = sat_none;
        foreach (fa[i]) begin
            pw = align(fa[i], fb[i]);
            if (i == 0) begin
                acc = pw;
            end else begin
                nxt = acc + pw;
                // first wrap of the frame decides the flag
                if (fl == sat_none && !acc[ACC_WIDTH-1] && !pw[ACC_WIDTH-1]
                        && nxt[ACC_WIDTH-1]) begin
                    fl = sat_over;
                end else if (fl == sat_none && acc[ACC_WIDTH-1] && pw[ACC_WIDTH-1]
                        && !nxt[ACC_WIDTH-1]) begin
                    fl = sat_under;
                end
                acc = nxt;
            end
        end
        case (fl)
            sat_over:  exp_sum_q.push_back(SUM_MAX);
            sat_under: exp_sum_q.push_back(SUM_MIN);
            default:   exp_sum_q.push_back(acc);
        endcase
        exp_flag_q.push_back(fl);
    endtask

    task automatic add_pairs(input int n, input int a, input int b);
        for (int i = 0; i < n; i++) begin
            fa.push_back(a);
            fb.push_back(b);
        end
    endtask

    task automatic send_sample(input int a, input int b, input logic sof, input logic eof);
        int cnt;
        @(posedge clk);
        in_a   <= IN_WIDTH'(a);
        in_b   <= IN_WIDTH'(b);
        in_sof <= sof;
        in_eof <= eof;
        in_req <= 1'b1;
        cnt = 0;
        while (!in_ack) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("in_ack did not rise");
        end
        if (cnt > max_ack_wait) max_ack_wait = cnt;
        in_req <= 1'b0;
        cnt = 0;
        while (in_ack) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("in_ack did not fall");
        end
    endtask

    task automatic send_frame();
        push_expected();
        foreach (fa[i]) begin
            send_sample(fa[i], fb[i], i == 0, i == fa.size() - 1);
        end
    endtask

    task automatic recv_result(input int ack_delay);
        int                          cnt;
        logic signed [ACC_WIDTH-1:0] exp_sum;
        sat_t                        exp_flag;
        cnt = 0;
        while (!out_req) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("out_req did not rise");
        end
        if (exp_sum_q.size() == 0) begin
            $display("A result arrived that no frame produced");
            protocol_errors++;
        end else begin
            exp_sum  = exp_sum_q.pop_front();
            exp_flag = exp_flag_q.pop_front();
            assert (out_sum == exp_sum) else begin
                $display("Fail out_sum: expected 0x%h, got 0x%h", exp_sum, out_sum);
                value_errors++;
            end
            assert (out_sat == exp_flag) else begin
                $display("Fail out_sat: expected 0x%h, got 0x%h", exp_flag, out_sat);
                value_errors++;
            end
        end
        repeat (ack_delay) @(posedge clk);
        out_ack <= 1'b1;
        cnt = 0;
        while (out_req) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) abort_run("out_req did not fall");
        end
        out_ack <= 1'b0;
    endtask

    task automatic test_single_sample();
        assert (in_ack == 1'b0) else begin
            $display("Fail in_ack: expected 0x0, got 0x%h", in_ack);
            value_errors++;
        end
        assert (out_req == 1'b0) else begin
            $display("Fail out_req: expected 0x0, got 0x%h", out_req);
            value_errors++;
        end
        fa.delete();
        fb.delete();
        add_pairs(1, 6144, -2560);
        send_frame();
        recv_result(0);
    endtask

    task automatic test_mixed_frame();
        fa = '{4096, -3072, 1234, -7, 3, 20000};
        fb = '{-2048, 1500, -999, 13, -5, -321};
        send_frame();
        recv_result(0);
    endtask

    // each full-scale product is 2^24 after alignment, so 128 of them wrap
    task automatic test_saturation();
        fa.delete();
        fb.delete();
        add_pairs(130, -32768, -32768);
        add_pairs(6, -32768, 32767);
        send_frame();
        recv_result(0);
        fa.delete();
        fb.delete();
        add_pairs(130, -32768, 32767);
        add_pairs(6, -32768, -32768);
        send_frame();
        recv_result(0);
    endtask

    task automatic test_clean_after_sat();
        fa = '{-30000, 12000, 517, -4096};
        fb = '{25000, -700, 8191, -4096};
        send_frame();
        recv_result(0);
    endtask

    task automatic test_back_pressure();
        int cnt;
        max_ack_wait = 0;
        fork
            begin
                logic signed [IN_WIDTH-1:0] va;
                logic signed [IN_WIDTH-1:0] vb;
                int                         len;
                for (int f = 0; f < 10; f++) begin
                    fa.delete();
                    fb.delete();
                    len = 1 + int'($unsigned($random(seed)) % 3);
                    for (int i = 0; i < len; i++) begin
                        va = IN_WIDTH'($random(seed));
                        vb = IN_WIDTH'($random(seed));
                        fa.push_back(int'(va));
                        fb.push_back(int'(vb));
                    end
                    send_frame();
                end
            end
            begin
                for (int r = 0; r < 10; r++) begin
                    recv_result(30);
                end
            end
        join
        assert (exp_sum_q.size() == 0) else begin
            $display("Some frames never returned a result");
            protocol_errors++;
        end
        assert (max_ack_wait > 20) else begin
            $display("in_ack never stalled while the result queue was full");
            protocol_errors++;
        end
        // nothing more may come out
        for (cnt = 0; cnt < 60; cnt++) begin
            @(posedge clk);
            assert (out_req == 1'b0) else begin
                $display("An extra result was offered after the last frame");
                protocol_errors++;
                break;
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        in_req  = 1'b0;
        in_a    = '0;
        in_b    = '0;
        in_sof  = 1'b0;
        in_eof  = 1'b0;
        out_ack = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        test_single_sample();
        test_mixed_frame();
        test_saturation();
        test_clean_after_sat();
        test_back_pressure();

        print_counts();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/dot_pkg.sv
verilog/sample_if.sv
verilog/req_ack_rx.sv
verilog/fixed_mult.sv
verilog/sat_acc.sv
verilog/result_tx.sv
verilog/frame_dot_top.sv
test/tb_frame_dot.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the frame dot-product testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_frame_dot \
    -Mdir obj_dir \
    -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    tail -n 20 "$BUILD_LOG"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$SIM_LOG"; then
    exit 0
else
    exit 1
fi
